/* hdl/gfx_pkg.sv */
/* shared widths, coordinate step constant, FSM state enums
   and the fixed 16-entry 12-bit colour palette */
`default_nettype none

package gfx_pkg;

    localparam int CORDW = 16;  // signed screen and buffer coords
    localparam int CIDXW = 4;   // colour index
    localparam int CHANW = 4;   // per colour channel

    localparam logic signed [CORDW-1:0] CORD_ONE = CORDW'(1);  // unit step

    // producer states
    typedef enum logic [2:0] {
        DS_IDLE,
        DS_WAIT_FRAME,
        DS_CLEAR,
        DS_DRAW,
        DS_DONE
    } draw_state_t;

    // line stepper states
    typedef enum logic [1:0] {
        LS_IDLE,
        LS_INIT,
        LS_DRAW,
        LS_DONE
    } line_state_t;

    // index to 12-bit rgb, entry 0 is black
    localparam logic [3*CHANW-1:0] PALETTE [2**CIDXW] = '{
        12'h000, 12'h125, 12'h723, 12'h085,
        12'hA53, 12'h655, 12'hCCC, 12'hFFF,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h2AF, 12'h87A, 12'hF7A, 12'hFCA
    };

endpackage

`default_nettype wire

/* hdl/display_timings.sv */
/* raster counters, negative-polarity syncs,
   data enable and frame/line start strobes */
`default_nettype none
`timescale 1ns/1ps

module display_timings import gfx_pkg::*; #(
    parameter int H_RES  = 640,  // active pixels per line
    parameter int V_RES  = 480,  // active lines per frame
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    output      logic signed [CORDW-1:0] sx,     // horizontal position
    output      logic signed [CORDW-1:0] sy,     // vertical position
    output      logic                    hsync,  // active low
    output      logic                    vsync,  // active low
    output      logic                    de,     // active area
    output      logic                    frame,  // first cycle of frame
    output      logic                    line    // first cycle of line
);

    // active area first, then front porch, sync, back porch
    localparam int HS_STA  = H_RES + H_FP;
    localparam int HS_END  = HS_STA + H_SYNC;
    localparam int H_TOTAL = HS_END + H_BP;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;
    localparam int V_TOTAL = VS_END + V_BP;

    logic h_last;  // last pixel of a line
    logic v_last;  // last line of a frame

    assign h_last = sx == H_TOTAL - 1;
    assign v_last = sy == V_TOTAL - 1;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (h_last) begin
            sx <= '0;
            sy <= v_last ? '0 : sy + CORD_ONE;  // wrap at frame end
        end else begin
            sx <= sx + CORD_ONE;
        end
    end

    // decoded straight from the counters so all outputs stay aligned with sx/sy
    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);
        vsync = ~(sy >= VS_STA && sy < VS_END);
        de    = sx < H_RES && sy < V_RES;
        frame = sx == 0 && sy == 0;  // raster origin
        line  = sx == 0;
    end

endmodule

`default_nettype wire

/* hdl/draw_line.sv */
/* Bresenham stepper for all octants,
   one pixel per enabled cycle, done pulse after the last pixel */
`default_nettype none
`timescale 1ns/1ps

module draw_line import gfx_pkg::*; (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    line_start,  // begin new line
    input  wire logic                    oe,          // may advance this cycle
    input  wire logic signed [CORDW-1:0] x0,
    input  wire logic signed [CORDW-1:0] y0,
    input  wire logic signed [CORDW-1:0] x1,
    input  wire logic signed [CORDW-1:0] y1,
    output      logic signed [CORDW-1:0] x,        // current pixel
    output      logic signed [CORDW-1:0] y,
    output      logic                    drawing,  // x/y valid and written
    output      logic                    done
);

    line_state_t state;

    logic                    swap;      // endpoints given bottom to top
    logic                    right_c;
    logic signed [CORDW-1:0] xa, ya;    // start at the top end
    logic signed [CORDW-1:0] xb, yb;    // finish at the bottom end
    logic signed [CORDW:0]   dx_c, dy_c;

    logic                    right;     // x steps positive
    logic signed [CORDW-1:0] x_end, y_end;
    logic signed [CORDW:0]   dx;        // abs x distance
    logic signed [CORDW:0]   dy;        // negated y distance
    logic signed [CORDW+1:0] err;       // error term
    logic signed [CORDW+2:0] e2;        // twice the error
    logic                    movx, movy;

    // order endpoints so y only ever increases
    always_comb begin
        swap    = y0 > y1;
        xa      = swap ? x1 : x0;
        ya      = swap ? y1 : y0;
        xb      = swap ? x0 : x1;
        yb      = swap ? y0 : y1;
        right_c = xa < xb;
        dx_c    = right_c ? xb - xa : xa - xb;
        dy_c    = ya - yb;  // zero or negative
    end

    always_comb begin
        e2   = {err, 1'b0};
        movx = e2 >= dy;
        movy = e2 <= dx;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= LS_IDLE;
        end else begin
            case (state)
                LS_IDLE: if (line_start) state <= LS_INIT;
                LS_INIT: begin  // register endpoints, deltas, direction
                    x     <= xa;
                    y     <= ya;
                    x_end <= xb;
                    y_end <= yb;
                    right <= right_c;
                    dx    <= dx_c;
                    dy    <= dy_c;
                    err   <= dx_c + dy_c;
                    state <= LS_DRAW;
                end
                LS_DRAW: if (oe) begin
                    if (x == x_end && y == y_end) begin
                        state <= LS_DONE;  // final pixel written this cycle
                    end else begin
                        if (movx) x <= right ? x + CORD_ONE : x - CORD_ONE;
                        if (movy) y <= y + CORD_ONE;
                        if (movx && movy) err <= err + dx + dy;
                        else if (movx) err <= err + dy;
                        else if (movy) err <= err + dx;
                    end
                end
                LS_DONE: state <= LS_IDLE;
                default: state <= LS_IDLE;
            endcase
        end
    end

    assign drawing = state == LS_DRAW && oe;  // held while oe low
    assign done    = state == LS_DONE;       // single cycle

endmodule

`default_nettype wire

/* hdl/draw_control.sv */
/* producer FSM that latches a line request, clears the
   framebuffer at frame start and then draws the line */
`default_nettype none
`timescale 1ns/1ps

module draw_control import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    start,    // request strobe
    input  wire logic signed [CORDW-1:0] x0,
    input  wire logic signed [CORDW-1:0] y0,
    input  wire logic signed [CORDW-1:0] x1,
    input  wire logic signed [CORDW-1:0] y1,
    input  wire logic [CIDXW-1:0]        cidx,     // line colour
    input  wire logic [CIDXW-1:0]        bg_cidx,  // clear colour
    input  wire logic                    frame,
    input  wire logic                    fb_busy,  // buffer refuses writes
    output      logic                    we,
    output      logic signed [CORDW-1:0] wx,
    output      logic signed [CORDW-1:0] wy,
    output      logic [CIDXW-1:0]        wcidx,
    output      logic                    busy,
    output      logic                    done
);

    draw_state_t state;

    logic signed [CORDW-1:0] lx0, ly0, lx1, ly1;  // latched request
    logic [CIDXW-1:0]        l_cidx, l_bg;
    logic signed [CORDW-1:0] cx, cy;              // clear walk address
    logic                    clr_last;
    logic                    line_start, line_drawing, line_done;
    logic signed [CORDW-1:0] lx, ly;              // stepper pixel

    assign clr_last = cx == FB_WIDTH - 1 && cy == FB_HEIGHT - 1;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state      <= DS_IDLE;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            case (state)
                DS_IDLE: if (start) state <= DS_WAIT_FRAME;
                DS_WAIT_FRAME: if (frame) begin
                    cx    <= '0;
                    cy    <= '0;
                    state <= DS_CLEAR;
                end
                DS_CLEAR: if (!fb_busy) begin  // step only when written
                    if (clr_last) begin
                        line_start <= 1'b1;
                        state      <= DS_DRAW;
                    end else if (cx == FB_WIDTH - 1) begin
                        cx <= '0;
                        cy <= cy + CORD_ONE;
                    end else begin
                        cx <= cx + CORD_ONE;
                    end
                end
                DS_DRAW: if (line_done) state <= DS_DONE;
                DS_DONE: state <= DS_IDLE;
                default: state <= DS_IDLE;
            endcase
        end
    end

    // capture request only when accepted
    always_ff @(posedge clk_pix) begin
        if (state == DS_IDLE && start) begin
            lx0    <= x0;
            ly0    <= y0;
            lx1    <= x1;
            ly1    <= y1;
            l_cidx <= cidx;
            l_bg   <= bg_cidx;
        end
    end

    draw_line i_draw_line (
        .clk_pix,
        .rst,
        .line_start,
        .oe      (!fb_busy),  // pause while display reads
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (lx),
        .y       (ly),
        .drawing (line_drawing),
        .done    (line_done)
    );

    // write port owner chosen by state
    always_comb begin
        if (state == DS_CLEAR) begin
            we    = !fb_busy;
            wx    = cx;
            wy    = cy;
            wcidx = l_bg;
        end else begin
            we    = line_drawing;  // low outside DS_DRAW
            wx    = lx;
            wy    = ly;
            wcidx = l_cidx;
        end
    end

    assign busy = state != DS_IDLE;
    assign done = state == DS_DONE;

endmodule

`default_nettype wire

/* hdl/framebuffer.sv */
/* block-RAM colour index store with bounds-checked,
   blank-time writes and a 2x scaled registered read */
`default_nettype none
`timescale 1ns/1ps

module framebuffer import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    we,
    input  wire logic signed [CORDW-1:0] wx,       // buffer coords
    input  wire logic signed [CORDW-1:0] wy,
    input  wire logic [CIDXW-1:0]        wcidx,
    input  wire logic signed [CORDW-1:0] sx,       // screen coords
    input  wire logic signed [CORDW-1:0] sy,
    input  wire logic                    de,
    output      logic                    fb_busy,
    output      logic [CIDXW-1:0]        rd_cidx   // one cycle after sx/sy
);

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    logic [CIDXW-1:0] mem [DEPTH];  // inferred bram

    logic                    w_in;   // write inside bounds
    logic [ADDRW-1:0]        waddr;
    logic signed [CORDW-1:0] rx, ry; // halved screen coords
    logic [ADDRW-1:0]        raddr;

    assign fb_busy = de;  // display has the memory in active area

    always_comb begin
        w_in  = wx >= 0 && wx < FB_WIDTH && wy >= 0 && wy < FB_HEIGHT;
        waddr = ADDRW'(wy * FB_WIDTH + wx);
    end

    // pixel doubling
    always_comb begin
        rx    = sx >>> 1;
        ry    = sy >>> 1;
        raddr = ADDRW'(ry * FB_WIDTH + rx);
    end

    always_ff @(posedge clk_pix) begin
        if (we && !de && w_in) mem[waddr] <= wcidx;  // clipped and blank time only
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            rd_cidx <= '0;
        end else if (!de) begin
            rd_cidx <= '0;  // background index in blanking
        end else begin
            rd_cidx <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* hdl/vga_output.sv */
/* sync delay to match the buffer read, palette lookup,
   blanking and registered VGA pins */
`default_nettype none
`timescale 1ns/1ps

module vga_output import gfx_pkg::*; (
    input  wire logic             clk_pix,
    input  wire logic             rst,
    input  wire logic             hsync,
    input  wire logic             vsync,
    input  wire logic             de,
    input  wire logic [CIDXW-1:0] rd_cidx,  // already one cycle late
    output      logic             vga_hsync,
    output      logic             vga_vsync,
    output      logic [CHANW-1:0] vga_r,
    output      logic [CHANW-1:0] vga_g,
    output      logic [CHANW-1:0] vga_b
);

    logic               hsync_p1, vsync_p1, de_p1;  // aligned with rd_cidx
    logic [3*CHANW-1:0] colr;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_p1 <= 1'b1;  // inactive high
            vsync_p1 <= 1'b1;
            de_p1    <= 1'b0;
        end else begin
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
            de_p1    <= de;
        end
    end

    assign colr = PALETTE[rd_cidx];

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= de_p1 ? colr[3*CHANW-1:2*CHANW] : '0;  // black in blanking
            vga_g     <= de_p1 ? colr[2*CHANW-1:CHANW]   : '0;
            vga_b     <= de_p1 ? colr[CHANW-1:0]         : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/line_display_top.sv */
/* display timings, line producer, framebuffer
   and VGA output joined on the pixel clock */
`default_nettype none
`timescale 1ns/1ps

module line_display_top import gfx_pkg::*; #(
    parameter int H_RES     = 640,
    parameter int V_RES     = 480,
    parameter int H_FP      = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BP      = 48,
    parameter int V_FP      = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BP      = 33,
    parameter int FB_WIDTH  = H_RES / 2,  // scale 2 buffer
    parameter int FB_HEIGHT = V_RES / 2
) (
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    start,
    input  wire logic signed [CORDW-1:0] x0,
    input  wire logic signed [CORDW-1:0] y0,
    input  wire logic signed [CORDW-1:0] x1,
    input  wire logic signed [CORDW-1:0] y1,
    input  wire logic [CIDXW-1:0]        cidx,
    input  wire logic [CIDXW-1:0]        bg_cidx,
    output      logic                    busy,
    output      logic                    done,
    output      logic                    vga_hsync,
    output      logic                    vga_vsync,
    output      logic [CHANW-1:0]        vga_r,
    output      logic [CHANW-1:0]        vga_g,
    output      logic [CHANW-1:0]        vga_b
);

    logic signed [CORDW-1:0] sx, sy;  // raster position
    logic                    hsync, vsync, de, frame;
    logic                    fb_we, fb_busy;
    logic signed [CORDW-1:0] fb_x, fb_y;  // write address
    logic [CIDXW-1:0]        fb_cidx, rd_cidx;

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_display_timings (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame,
        .line ()
    );

    draw_control #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_draw_control (
        .clk_pix, .rst, .start, .x0, .y0, .x1, .y1, .cidx, .bg_cidx,
        .frame, .fb_busy,
        .we    (fb_we),
        .wx    (fb_x),
        .wy    (fb_y),
        .wcidx (fb_cidx),
        .busy, .done
    );

    framebuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_framebuffer (
        .clk_pix, .rst,
        .we    (fb_we),
        .wx    (fb_x),
        .wy    (fb_y),
        .wcidx (fb_cidx),
        .sx, .sy, .de, .fb_busy, .rd_cidx
    );

    vga_output i_vga_output (
        .clk_pix, .rst, .hsync, .vsync, .de, .rd_cidx,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

`default_nettype wire

/* verif/line_display_assert.sv */
/* concurrent checks on done, busy, write gating and blanking,
   bound into the line display top level */
`default_nettype none
`timescale 1ns/1ps

module line_display_assert import gfx_pkg::*; (
    input wire logic             clk_pix,
    input wire logic             rst,
    input wire logic             busy,
    input wire logic             done,
    input wire logic             fb_we,
    input wire logic             fb_busy,
    input wire logic             de,     // raster active area, two cycles ahead of the pins
    input wire logic [CHANW-1:0] vga_r,
    input wire logic [CHANW-1:0] vga_g,
    input wire logic [CHANW-1:0] vga_b
);

    int fails = 0;  // assertion failure count

    done_pulse: assert property (@(posedge clk_pix) disable iff (rst) done |=> !done)
        else begin
            fails++;
            $error("done held for more than one cycle");
        end

    busy_end: assert property (@(posedge clk_pix) disable iff (rst) $fell(busy) |-> $past(done))
        else begin
            fails++;
            $error("busy fell without a done pulse");
        end

    write_gate: assert property (@(posedge clk_pix) disable iff (rst) !(fb_we && fb_busy))
        else begin
            fails++;
            $error("framebuffer write while display reads");
        end

    // blanking reaches the pins after the buffer read and the output register
    blank_black: assert property (@(posedge clk_pix) disable iff (rst)
                                  !de |-> ##2 ({vga_r, vga_g, vga_b} == '0))
        else begin
            fails++;
            $error("colour not black in blanking");
        end

endmodule

bind line_display_top line_display_assert i_line_display_assert (
    .clk_pix, .rst, .busy, .done, .fb_we, .fb_busy, .de,
    .vga_r, .vga_g, .vga_b
);

`default_nettype wire

/* verif/tb_line_display.sv */
/* directed testbench for the line display top level with clock and reset,
   raster monitor, Bresenham reference image, tests and watchdog */
`default_nettype none
`timescale 1ns/1ps

module tb_line_display import gfx_pkg::*; ();

    localparam int H_RES   = 32;
    localparam int V_RES   = 16;
    localparam int H_FP    = 2;
    localparam int H_SYNC  = 4;
    localparam int H_BP    = 2;
    localparam int V_FP    = 1;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 1;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 40 cycles
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 20 lines
    localparam int HS_STA  = H_RES + H_FP;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int FB_W    = H_RES / 2;
    localparam int FB_H    = V_RES / 2;
    localparam int FRAME   = H_TOTAL * V_TOTAL;  // cycles per frame
    localparam int N_TESTS = 9;
    localparam int DONE_LIMIT = 3 * FRAME;  // wait frame, clear, draw

    logic                    clk_pix, rst, start, busy, done;
    logic signed [CORDW-1:0] x0, y0, x1, y1;
    logic [CIDXW-1:0]        cidx, bg_cidx;
    logic                    vga_hsync, vga_vsync;
    logic [CHANW-1:0]        vga_r, vga_g, vga_b;

    integer seed = 32'h97d3a56e;
    int     errors, checks;
    int     hpos, vpos;                 // rebuilt screen position
    int     frames_begun, frames_done;
    bit     h_lock, v_lock;
    logic   hs_q, vs_q;
    logic [3*CHANW-1:0] scr [V_RES][H_RES];    // last captured frame
    logic [CIDXW-1:0]   ref_fb [FB_H][FB_W];   // expected buffer

    line_display_top #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .FB_WIDTH(FB_W), .FB_HEIGHT(FB_H)
    ) i_line_display_top (
        .clk_pix, .rst, .start, .x0, .y0, .x1, .y1, .cidx, .bg_cidx,
        .busy, .done, .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;  // 100 ns period
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // sync falls mark sx = HS_STA and sy = VS_STA after the fixed output lag
    always @(negedge clk_pix) begin
        if (rst) begin
            h_lock = 1'b0;
            v_lock = 1'b0;
            hs_q   = 1'b1;
            vs_q   = 1'b1;
        end else begin
            if (hs_q && !vga_hsync) begin
                hpos   = HS_STA;
                h_lock = 1'b1;
            end else begin
                hpos = (hpos + 1) % H_TOTAL;
            end
            if (vs_q && !vga_vsync) begin
                vpos   = VS_STA;  // vsync falls on a line start
                v_lock = 1'b1;
            end else if (hpos == 0) begin
                vpos = (vpos + 1) % V_TOTAL;
            end
            hs_q = vga_hsync;
            vs_q = vga_vsync;
            if (h_lock && v_lock) begin
                if (hpos < H_RES && vpos < V_RES) begin
                    if (hpos == 0 && vpos == 0) frames_begun++;
                    scr[vpos][hpos] = {vga_r, vga_g, vga_b};
                    if (hpos == H_RES - 1 && vpos == V_RES - 1) frames_done++;
                end else begin
                    check({vga_r, vga_g, vga_b}, 0, "colour outside active window");
                end
            end
        end
    end

    // cycles to the next falling edge and low samples seen on the way
    task automatic sync_fall(input bit vert, output int cycles, output int low);
        logic s, prev;
        cycles = 0;
        low    = 0;
        s      = vert ? vga_vsync : vga_hsync;
        forever begin
            prev = s;
            if (!prev) low++;
            @(negedge clk_pix);
            cycles++;
            s = vert ? vga_vsync : vga_hsync;
            if (prev && !s) break;
        end
    endtask

    task automatic pick_colours(output logic [CIDXW-1:0] c, output logic [CIDXW-1:0] bg);
        int r;
        r  = $random(seed);
        c  = r[3:0];
        bg = r[7:4];
        if (bg == c) bg = c + 4'd5;  // keep line visible
    endtask

    // Bresenham from the upper end with clipping to the buffer
    task automatic draw_ref(input int ax0, input int ay0, input int ax1, input int ay1,
                            input logic [CIDXW-1:0] c, input logic [CIDXW-1:0] bg);
        int xa, ya, xb, yb, dx, dy, err, e2, stepx;
        foreach (ref_fb[i, j]) ref_fb[i][j] = bg;
        xa = ay0 > ay1 ? ax1 : ax0;
        ya = ay0 > ay1 ? ay1 : ay0;
        xb = ay0 > ay1 ? ax0 : ax1;
        yb = ay0 > ay1 ? ay0 : ay1;
        dx    = xb > xa ? xb - xa : xa - xb;
        dy    = ya - yb;  // never positive
        stepx = xa < xb ? 1 : -1;
        err   = dx + dy;
        forever begin
            if (xa >= 0 && xa < FB_W && ya >= 0 && ya < FB_H) ref_fb[ya][xa] = c;
            if (xa == xb && ya == yb) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                xa  += stepx;
            end
            if (e2 <= dx) begin
                err += dx;
                ya++;
            end
        end
    endtask

    task automatic request(input int ax0, input int ay0, input int ax1, input int ay1,
                           input logic [CIDXW-1:0] c, input logic [CIDXW-1:0] bg);
        x0      = CORDW'(ax0);
        y0      = CORDW'(ay0);
        x1      = CORDW'(ax1);
        y1      = CORDW'(ay1);
        cidx    = c;
        bg_cidx = bg;
        start   = 1'b1;
        @(negedge clk_pix);
        start = 1'b0;
        check(busy, 1, "busy one cycle after start");
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_LIMIT) begin
            @(negedge clk_pix);
            n++;
        end
        if (!done) begin
            errors++;
            $display("done never arrived within %0d cycles of the request", DONE_LIMIT);
        end else begin
            @(negedge clk_pix);
            check(done, 0, "done lasts one cycle");
            check(busy, 0, "busy drops after done");
        end
    endtask

    // a whole frame that starts after done
    task automatic capture_frame();
        int fb0, fd0;
        fb0 = frames_begun;
        wait (frames_begun != fb0);
        fd0 = frames_done;
        wait (frames_done != fd0);
        @(negedge clk_pix);
    endtask

    task automatic compare_frame(input string name);
        for (int y = 0; y < V_RES; y++) begin
            for (int x = 0; x < H_RES; x++) begin
                check(scr[y][x], PALETTE[ref_fb[y/2][x/2]],
                      $sformatf("%s pixel (%0d,%0d)", name, x, y));
            end
        end
    endtask

    task automatic test_reset();
        check(busy, 0, "busy after reset");
        check(done, 0, "done after reset");
        check(vga_hsync, 1, "hsync idle high");
        check(vga_vsync, 1, "vsync idle high");
        check({vga_r, vga_g, vga_b}, 0, "colour after reset");
    endtask

    task automatic test_raster();
        int cyc, low;
        sync_fall(1'b0, cyc, low);  // align only
        sync_fall(1'b0, cyc, low);
        check(cyc, H_TOTAL, "hsync period");
        check(low, H_SYNC, "hsync width");
        sync_fall(1'b1, cyc, low);
        sync_fall(1'b1, cyc, low);
        check(cyc % H_TOTAL, 0, "vsync period in whole lines");
        check(cyc / H_TOTAL, V_TOTAL, "vsync period in lines");
        check(low, V_SYNC * H_TOTAL, "vsync width");
    endtask

    task automatic test_line(input int ax0, input int ay0, input int ax1, input int ay1,
                             input string name);
        logic [CIDXW-1:0] c, bg;
        pick_colours(c, bg);
        draw_ref(ax0, ay0, ax1, ay1, c, bg);
        request(ax0, ay0, ax1, ay1, c, bg);
        wait_done();
        capture_frame();
        compare_frame(name);
    endtask

    task automatic test_busy_start();
        logic [CIDXW-1:0] c, bg;
        pick_colours(c, bg);
        draw_ref(1, 7, 14, 0, c, bg);
        request(1, 7, 14, 0, c, bg);
        request(0, 0, 15, 7, bg, c);  // dropped while in WAIT_FRAME
        wait_done();
        capture_frame();
        compare_frame("first line only");
        pick_colours(c, bg);
        draw_ref(15, 2, 0, 5, c, bg);
        request(15, 2, 0, 5, c, bg);
        wait_done();
        capture_frame();
        compare_frame("replacement image");
    endtask

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        x0      = '0;
        y0      = '0;
        x1      = '0;
        y1      = '0;
        cidx    = '0;
        bg_cidx = '0;
        repeat (10) @(negedge clk_pix);
        test_reset();  // values held by reset
        rst = 1'b0;
        @(negedge clk_pix);
        test_raster();
        test_line(2, 3, 13, 3, "horizontal line");
        test_line(14, 6, 1, 1, "reversed shallow line");
        test_line(3, 0, 6, 7, "steep line");
        test_line(12, 7, 10, 0, "steep reversed line");
        test_line(15, 0, 0, 7, "falling shallow line");
        test_line(-4, -2, 20, 9, "clipped line");
        test_busy_start();
        errors += i_line_display_top.i_line_display_assert.fails;
        $display("checks %0d, errors %0d (assertion failures %0d)", checks, errors,
                 i_line_display_top.i_line_display_assert.fails);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // four frame times per test
    initial begin
        #(N_TESTS * 4 * FRAME * 100);
        $display("timeout, tests did not finish within %0d frame times", N_TESTS * 4);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/gfx_pkg.sv
hdl/display_timings.sv
hdl/draw_line.sv
hdl/draw_control.sv
hdl/framebuffer.sv
hdl/vga_output.sv
hdl/line_display_top.sv
verif/line_display_assert.sv
verif/tb_line_display.sv
